//--- hdl/gfx_pkg.sv
/*
 * Tile layer shared definitions
 * Memory sizes, control page decode and fetch engine states
 */
`default_nettype none

package gfx_pkg;

    // Video RAM words: 2 pages x 32 rows x 32 columns
    localparam int VRAM_AW = 11;
    // Scroll RAM bytes, first 32 used as column scroll
    localparam int YRAM_AW = 8;
    // CPU byte address, bit 12 picks the VRAM high lane
    localparam int CPU_AW = 13;

    localparam int TILE_COLS = 32;
    localparam int LINE_PIXELS = 256;

    // Control space page, taken from cpu_addr[11:8]
    typedef enum logic [3:0] {
        PAGE_YRAM = 4'd0,
        PAGE_CFG  = 4'd3
    } vctrl_page_t;

    // Per-column fetch sequence
    typedef enum logic [2:0] {
        F_IDLE,
        F_CODE,
        F_SCROLL,
        F_ROM,
        F_WRITE
    } fetch_state_t;

endpackage

`default_nettype wire

//--- hdl/tile_cfg_if.sv
/*
 * Tile layer configuration bundle
 * Carries the decoded config bits from the registers to the fetch engine
 */
`timescale 1ns/1ps
`default_nettype none

interface tile_cfg_if;
    logic flip;
    logic page;
    logic video_en;
    logic col_scroll_en;

    // Register block drives, fetch engine listens
    modport regs (output flip, page, video_en, col_scroll_en);
    modport fetch (input flip, page, video_en, col_scroll_en);
endinterface

`default_nettype wire

//--- hdl/dual_port_ram.sv
/*
 * Two-port synchronous RAM
 * Port A reads and writes per byte lane, port B is read only
 */
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int aw    = 8,
    parameter int dw    = 8,
    parameter int lanes = 1
) (
    input  wire              clk,
    // CPU side
    input  wire  [aw-1:0]    a_addr,
    input  wire  [dw-1:0]    a_wdata,
    input  wire  [lanes-1:0] a_we,
    output logic [dw-1:0]    a_q,
    // Graphics side
    input  wire  [aw-1:0]    b_addr,
    output logic [dw-1:0]    b_q
);

    logic [dw-1:0] mem [0:(2**aw)-1];

    // Lane writes, read returns the old word
    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (a_we[i]) begin
                mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
            end
        end
        a_q <= mem[a_addr];
    end

    // Fetch engine read port
    always_ff @(posedge clk) begin
        b_q <= mem[b_addr];
    end

endmodule

`default_nettype wire

//--- hdl/gfx_regs.sv
/*
 * CPU side of the tile layer
 * Address decode, RAM write enables, config registers and read-back mux
 */
`timescale 1ns/1ps
`default_nettype none

module gfx_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cpu_rnw,
    input  wire  [gfx_pkg::CPU_AW-1:0] cpu_addr,
    input  wire  [7:0]                 cpu_wdata,
    input  wire                        vram_cs,
    input  wire                        vctrl_cs,
    input  wire  [15:0]                vram_q,
    input  wire  [7:0]                 yram_q,
    output logic [1:0]                 vram_we,
    output logic                       yram_we,
    output logic [7:0]                 cpu_din,
    tile_cfg_if.regs                   cfg
);
    import gfx_pkg::*;

    vctrl_page_t page_sel;
    logic        yram_cs;
    logic        cfg_cs;
    logic [7:0]  cfg_r [0:3];
    // Read source, held for one cycle to match RAM latency
    logic        rd_vram;
    logic        rd_hi;
    logic        rd_yram;

    // Page field of the control space
    assign page_sel = vctrl_page_t'(cpu_addr[11:8]);
    assign yram_cs  = vctrl_cs && (page_sel == PAGE_YRAM);
    assign cfg_cs   = vctrl_cs && (page_sel == PAGE_CFG);

    // Bit 12 steers the byte into one VRAM lane
    assign vram_we = {2{vram_cs & ~cpu_rnw}} & {cpu_addr[12], ~cpu_addr[12]};
    assign yram_we = yram_cs & ~cpu_rnw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                cfg_r[i] <= 8'd0;
            end
            rd_vram <= 1'b0;
            rd_hi   <= 1'b0;
            rd_yram <= 1'b0;
        end else begin
            if (cfg_cs && !cpu_rnw) begin
                cfg_r[cpu_addr[1:0]] <= cpu_wdata;
            end
            rd_vram <= vram_cs & cpu_rnw;
            rd_hi   <= cpu_addr[12];
            rd_yram <= yram_cs & cpu_rnw;
        end
    end

    // Config and unmapped reads float high
    assign cpu_din = rd_yram ? yram_q :
                     rd_vram ? (rd_hi ? vram_q[15:8] : vram_q[7:0]) : 8'hff;

    // Layer controls
    assign cfg.flip          = cfg_r[0][6];
    assign cfg.video_en      = cfg_r[0][4];
    assign cfg.page          = cfg_r[1][6];
    assign cfg.col_scroll_en = cfg_r[1][4];

endmodule

`default_nettype wire

//--- hdl/tilemap_fetch.sv
/*
 * Per-line tile fetch engine
 * Walks 32 columns on hs, reads scroll, map and ROM, then writes 8 pixels each
 */
`timescale 1ns/1ps
`default_nettype none

module tilemap_fetch (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         hs,
    input  wire  [8:0]                  vrender,
    input  wire  [15:0]                 vram_q,
    input  wire  [7:0]                  yram_q,
    input  wire                         scr_ok,
    input  wire  [31:0]                 scr_data,
    output logic [gfx_pkg::VRAM_AW-1:0] vram_addr,
    output logic [gfx_pkg::YRAM_AW-1:0] yram_addr,
    output logic [14:0]                 scr_addr,
    output logic                        scr_cs,
    output logic [7:0]                  lb_addr,
    output logic [7:0]                  lb_data,
    output logic                        lb_we,
    tile_cfg_if.fetch                   cfg
);
    import gfx_pkg::*;

    fetch_state_t state;
    logic         hs_l;
    logic         hs_rise;
    logic [4:0]   col;
    logic [2:0]   k;
    logic [7:0]   ybase;
    logic [7:0]   y_eff;
    logic [31:0]  pixels;

    assign hs_rise = hs & ~hs_l;

    // Scroll byte of the current column
    assign yram_addr = YRAM_AW'(col);

    // Effective line, scroll wraps within 256
    assign y_eff = ybase + (cfg.col_scroll_en ? yram_q : 8'd0);

    // Map word index: page, tile row, column
    assign vram_addr = {cfg.page, y_eff[7:3], col};

    // Address and strobe stay put until the state leaves F_ROM
    assign scr_addr = {vram_q[11:0], y_eff[2:0]};
    assign scr_cs   = (state == F_ROM);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= F_IDLE;
            hs_l  <= 1'b0;
            col   <= 5'd0;
            k     <= 3'd0;
            lb_we <= 1'b0;
        end else begin
            hs_l  <= hs;
            lb_we <= (state == F_WRITE);
            case (state)
                F_IDLE: begin
                    if (hs_rise) begin
                        col   <= 5'd0;
                        state <= F_SCROLL;
                    end
                end
                // yram_q valid at the end of this cycle
                F_SCROLL: state <= F_CODE;
                // map word lands in vram_q
                F_CODE: state <= F_ROM;
                F_ROM: begin
                    if (scr_ok) begin
                        k     <= 3'd0;
                        state <= F_WRITE;
                    end
                end
                F_WRITE: begin
                    k <= k + 3'd1;
                    if (k == 3'd7) begin
                        if (col == 5'(TILE_COLS - 1)) begin
                            state <= F_IDLE;
                        end else begin
                            col   <= col + 5'd1;
                            state <= F_SCROLL;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Line base, pixel shifter and buffer write data
    always_ff @(posedge clk) begin
        if (state == F_IDLE && hs_rise) begin
            ybase <= cfg.flip ? ~vrender[7:0] : vrender[7:0];
        end
        if (state == F_ROM && scr_ok) begin
            pixels <= scr_data;
        end else if (state == F_WRITE) begin
            // Leftmost pixel sits in the top nibble
            pixels <= pixels << 4;
        end
        lb_addr <= {col, k};
        lb_data <= cfg.video_en ? {vram_q[15:12], pixels[31:28]} : 8'd0;
    end

endmodule

`default_nettype wire

//--- hdl/line_buffer.sv
/*
 * Double-banked line store
 * Fetch engine fills the back bank while the front bank is scanned out
 */
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire        clk,
    input  wire        rst,
    input  wire        hs,
    input  wire  [7:0] lb_addr,
    input  wire  [7:0] lb_data,
    input  wire        lb_we,
    input  wire        pxl_cen,
    input  wire  [8:0] hdump,
    output logic [7:0] scr_pxl
);
    import gfx_pkg::*;

    // Both banks in one array, bank bit on top
    logic [7:0] mem [0:(2*LINE_PIXELS)-1];
    logic       wr_bank;
    logic       hs_l;

    // Fill side
    always_ff @(posedge clk) begin
        if (lb_we) begin
            mem[{wr_bank, lb_addr}] <= lb_data;
        end
    end

    // Swap on hs, scan the bank filled last line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_l    <= 1'b0;
            wr_bank <= 1'b0;
            scr_pxl <= 8'd0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) begin
                wr_bank <= ~wr_bank;
            end
            if (pxl_cen) begin
                scr_pxl <= mem[{~wr_bank, hdump[7:0]}];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/gfx_top.sv
/*
 * Tile layer top level
 * CPU bus, tile ROM and video timing ports around the layer blocks
 */
`timescale 1ns/1ps
`default_nettype none

module gfx_top (
    input  wire                        clk,
    input  wire                        rst,
    // CPU bus
    input  wire                        cpu_rnw,
    input  wire  [gfx_pkg::CPU_AW-1:0] cpu_addr,
    input  wire  [7:0]                 cpu_wdata,
    input  wire                        vram_cs,
    input  wire                        vctrl_cs,
    output wire  [7:0]                 cpu_din,
    // Tile ROM
    output wire  [14:0]                scr_addr,
    output wire                        scr_cs,
    input  wire                        scr_ok,
    input  wire  [31:0]                scr_data,
    // Video timing
    input  wire                        hs,
    input  wire                        pxl_cen,
    input  wire  [8:0]                 vrender,
    input  wire  [8:0]                 hdump,
    output wire                        flip,
    output wire  [7:0]                 scr_pxl
);
    import gfx_pkg::*;

    wire [1:0]         vram_we;
    wire               yram_we;
    wire [15:0]        vram_cpu_q;
    wire [7:0]         yram_cpu_q;
    wire [VRAM_AW-1:0] vram_addr;
    wire [15:0]        vram_gfx_q;
    wire [YRAM_AW-1:0] yram_addr;
    wire [7:0]         yram_gfx_q;
    wire [7:0]         lb_addr;
    wire [7:0]         lb_data;
    wire               lb_we;

    tile_cfg_if cfg ();

    assign flip = cfg.flip;

    gfx_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cpu_rnw   (cpu_rnw),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .vram_cs   (vram_cs),
        .vctrl_cs  (vctrl_cs),
        .vram_q    (vram_cpu_q),
        .yram_q    (yram_cpu_q),
        .vram_we   (vram_we),
        .yram_we   (yram_we),
        .cpu_din   (cpu_din),
        .cfg       (cfg.regs)
    );

    // Tile map, byte written to both lanes
    dual_port_ram #(.aw(VRAM_AW), .dw(16), .lanes(2)) u_vram (
        .clk     (clk),
        .a_addr  (cpu_addr[VRAM_AW-1:0]),
        .a_wdata ({2{cpu_wdata}}),
        .a_we    (vram_we),
        .a_q     (vram_cpu_q),
        .b_addr  (vram_addr),
        .b_q     (vram_gfx_q)
    );

    // Column scroll bytes
    dual_port_ram #(.aw(YRAM_AW), .dw(8), .lanes(1)) u_yram (
        .clk     (clk),
        .a_addr  (cpu_addr[YRAM_AW-1:0]),
        .a_wdata (cpu_wdata),
        .a_we    (yram_we),
        .a_q     (yram_cpu_q),
        .b_addr  (yram_addr),
        .b_q     (yram_gfx_q)
    );

    tilemap_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .vrender   (vrender),
        .vram_q    (vram_gfx_q),
        .yram_q    (yram_gfx_q),
        .scr_ok    (scr_ok),
        .scr_data  (scr_data),
        .vram_addr (vram_addr),
        .yram_addr (yram_addr),
        .scr_addr  (scr_addr),
        .scr_cs    (scr_cs),
        .lb_addr   (lb_addr),
        .lb_data   (lb_data),
        .lb_we     (lb_we),
        .cfg       (cfg.fetch)
    );

    line_buffer u_line (
        .clk     (clk),
        .rst     (rst),
        .hs      (hs),
        .lb_addr (lb_addr),
        .lb_data (lb_data),
        .lb_we   (lb_we),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .scr_pxl (scr_pxl)
    );

endmodule

`default_nettype wire

//--- tests/gfx_tb.sv
/*
 * Tile layer testbench
 * Replays CPU accesses and line renders from a case file, with a tile ROM
 * model of random latency and shadow copies of the layer memories
 */
`timescale 1ns/1ps
`default_nettype none

module gfx_tb;
    import gfx_pkg::*;

    localparam int VRAM_WORDS = 1 << VRAM_AW;
    localparam int YRAM_BYTES = 1 << YRAM_AW;
    // Longest fetch is 32 x 14 cycles
    localparam int LINE_WAIT  = 700;

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_rnw;
    logic [CPU_AW-1:0] cpu_addr;
    logic [7:0]        cpu_wdata;
    logic              vram_cs;
    logic              vctrl_cs;
    wire  [7:0]        cpu_din;
    wire  [14:0]       scr_addr;
    wire               scr_cs;
    logic              scr_ok = 1'b0;
    logic [31:0]       scr_data = 32'd0;
    logic              hs;
    logic              pxl_cen;
    logic [8:0]        vrender;
    logic [8:0]        hdump;
    wire               flip;
    wire  [7:0]        scr_pxl;

    // Shadow copies of what the CPU wrote
    logic [15:0] shadow_vram [0:VRAM_WORDS-1];
    logic [7:0]  shadow_yram [0:YRAM_BYTES-1];
    logic [7:0]  shadow_cfg  [0:3];

    // Operations parsed from the case file
    logic [7:0]  case_op   [$];
    logic [7:0]  case_kind [$];
    logic [12:0] case_addr [$];
    logic [7:0]  case_data [$];

    // ROM model state
    logic [15:0] lfsr = 16'd69;
    int          rom_wait = 0;
    logic        rom_armed = 1'b0;

    // Expected ROM request of the column being fetched
    logic [14:0] req_addr = 15'd0;
    int          req_col = 0;
    int          rom_errs = 0;

    int cycles = 0;
    int cycle_limit;
    int n_fail;
    int n_errors;

    gfx_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_rnw   (cpu_rnw),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .vram_cs   (vram_cs),
        .vctrl_cs  (vctrl_cs),
        .cpu_din   (cpu_din),
        .scr_addr  (scr_addr),
        .scr_cs    (scr_cs),
        .scr_ok    (scr_ok),
        .scr_data  (scr_data),
        .hs        (hs),
        .pxl_cen   (pxl_cen),
        .vrender   (vrender),
        .hdump     (hdump),
        .flip      (flip),
        .scr_pxl   (scr_pxl)
    );

    always #2 clk = ~clk;

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | {31'd0, lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Nibble k counts up from the low address nibble
    function automatic logic [31:0] rom_word(input logic [14:0] a);
        logic [31:0] w;
        w = 32'd0;
        for (int k = 0; k < 8; k++) begin
            w[31 - 4*k -: 4] = a[3:0] + 4'(k);
        end
        return w;
    endfunction

    // Bijective fills so every address holds its own value
    function automatic logic [15:0] fill_word(input int i);
        return 16'(i * 40503) ^ 16'h5a5a;
    endfunction

    function automatic logic [7:0] fill_byte(input int i);
        return 8'(i * 101) ^ 8'h3c;
    endfunction

    // Line of a column after flip and scroll
    function automatic logic [7:0] column_y(input logic [8:0] line, input logic [4:0] col);
        logic [7:0] y;
        y = shadow_cfg[0][6] ? 8'hff - line[7:0] : line[7:0];
        if (shadow_cfg[1][4]) begin
            y = y + shadow_yram[{3'd0, col}];
        end
        return y;
    endfunction

    // Map word from page, tile row and column
    function automatic logic [15:0] column_word(input logic [7:0] y, input logic [4:0] col);
        return shadow_vram[{shadow_cfg[1][6], y[7:3], col}];
    endfunction

    // ROM row address, tile code then fine row
    function automatic logic [14:0] rom_addr_of(input logic [8:0] line, input logic [4:0] col);
        logic [7:0]  y;
        logic [15:0] w;
        y = column_y(line, col);
        w = column_word(y, col);
        return {w[11:0], y[2:0]};
    endfunction

    // Tile ROM, answers 1 to 4 cycles after the request
    always @(negedge clk) begin
        if (!scr_cs) begin
            scr_ok = 1'b0;
            rom_armed = 1'b0;
        end else begin
            // Strobe drops on the edge that takes the data
            if (scr_ok) begin
                $display("** Error (%0t): scr_cs still high after scr_ok", $time);
                rom_errs++;
            end
            if (!rom_armed) begin
                rom_armed = 1'b1;
                take_bits(2, rom_wait);
                req_addr = rom_addr_of(vrender, 5'(req_col));
                req_col++;
            end else if (rom_wait > 0) begin
                rom_wait = rom_wait - 1;
            end
            // Address of this column, held for the whole request
            if (scr_addr !== req_addr) begin
                $display("** Error (%0t): scr_addr %h expected %h", $time, scr_addr, req_addr);
                rom_errs++;
            end
            if (rom_wait == 0) begin
                scr_ok = 1'b1;
                scr_data = rom_word(scr_addr);
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    // One bus cycle, called and returning on a falling edge
    task automatic cpu_access(input logic is_vram, input logic rnw, input logic [12:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        cpu_addr = addr;
        cpu_wdata = wdata;
        cpu_rnw = rnw;
        vram_cs = is_vram;
        vctrl_cs = ~is_vram;
        @(negedge clk);
        vram_cs = 1'b0;
        vctrl_cs = 1'b0;
        cpu_rnw = 1'b1;
        // Read data lands one clock after the access
        rdata = cpu_din;
    endtask

    task automatic apply_shadow(input logic [7:0] kind, input logic [12:0] addr,
                                input logic [7:0] data);
        if (kind == "V") begin
            if (addr[12]) begin
                shadow_vram[addr[10:0]][15:8] = data;
            end else begin
                shadow_vram[addr[10:0]][7:0] = data;
            end
        end else if (addr[11:8] == 4'(PAGE_YRAM)) begin
            shadow_yram[addr[7:0]] = data;
        end else if (addr[11:8] == 4'(PAGE_CFG)) begin
            shadow_cfg[addr[1:0]] = data;
        end
    endtask

    task automatic preload_memories();
        logic [15:0] w;
        logic [7:0]  unused;
        for (int i = 0; i < VRAM_WORDS; i++) begin
            w = fill_word(i);
            cpu_access(1'b1, 1'b0, 13'(i), w[7:0], unused);
            cpu_access(1'b1, 1'b0, 13'(i) | 13'h1000, w[15:8], unused);
            shadow_vram[i] = w;
        end
        // Scroll RAM is page 0 of the control space
        for (int i = 0; i < YRAM_BYTES; i++) begin
            cpu_access(1'b0, 1'b0, 13'(i), fill_byte(i), unused);
            shadow_yram[i] = fill_byte(i);
        end
    endtask

    // Flip, scroll, page, map word, ROM nibble, palette
    function automatic logic [7:0] expect_pixel(input logic [8:0] line, input int x);
        logic [4:0]  col;
        logic [2:0]  k;
        logic [7:0]  y;
        logic [15:0] w;
        logic [31:0] rom;
        col = x[7:3];
        k = x[2:0];
        y = column_y(line, col);
        w = column_word(y, col);
        rom = rom_word({w[11:0], y[2:0]});
        if (!shadow_cfg[0][4]) begin
            return 8'd0;
        end
        return {w[15:12], rom[31 - 4*k -: 4]};
    endfunction

    task automatic run_line(input logic [8:0] line, output int errs);
        logic [7:0] want;
        int         rom_errs_start;
        errs = 0;
        rom_errs_start = rom_errs;
        vrender = line;
        req_col = 0;
        hs = 1'b1;
        @(negedge clk);
        hs = 1'b0;
        repeat (LINE_WAIT) @(negedge clk);
        // Second edge swaps banks so the new line is scanned out
        req_col = 0;
        hs = 1'b1;
        @(negedge clk);
        hs = 1'b0;
        for (int x = 0; x < LINE_PIXELS; x++) begin
            hdump = 9'(x);
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            want = expect_pixel(line, x);
            if (scr_pxl !== want) begin
                $display("** Error (%0t): line %h pixel %0d got %h expected %h",
                         $time, line, x, scr_pxl, want);
                errs++;
            end
            @(negedge clk);
        end
        // ROM requests of both fetches
        errs += rom_errs - rom_errs_start;
    endtask

    task automatic read_cases(output logic ok);
        int               fd;
        int               got;
        logic [7:0]       op;
        logic [7:0]       kind;
        logic [12:0]      addr;
        logic [7:0]       data;
        logic [8*128-1:0] rest;
        fd = $fopen("tests/gfx_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                got = $fscanf(fd, " %c", op);
                if (got == 1 && op == "#") begin
                    got = $fgets(rest, fd);
                end else if (got == 1) begin
                    kind = "-";
                    data = 8'd0;
                    if (op == "L") begin
                        got = $fscanf(fd, " %h", addr);
                    end else begin
                        got = $fscanf(fd, " %c %h %h", kind, addr, data);
                    end
                    case_op.push_back(op);
                    case_kind.push_back(kind);
                    case_addr.push_back(addr);
                    case_data.push_back(data);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic       ok;
        logic [7:0] rdata;
        int         errs;
        rst = 1'b1;
        cpu_rnw = 1'b1;
        cpu_addr = '0;
        cpu_wdata = 8'd0;
        vram_cs = 1'b0;
        vctrl_cs = 1'b0;
        hs = 1'b0;
        pxl_cen = 1'b0;
        vrender = 9'd0;
        hdump = 9'd0;
        cycle_limit = 0;
        n_fail = 0;
        n_errors = 0;
        for (int i = 0; i < 4; i++) begin
            shadow_cfg[i] = 8'd0;
        end
        read_cases(ok);
        if (!ok) begin
            $display("Could not open the case file tests/gfx_cases.txt");
            $display("test failed");
            $finish;
        end else begin
            cycle_limit = 2000 * case_op.size() + 4 * (2 * VRAM_WORDS + YRAM_BYTES) + 100;
            repeat (10) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            if (flip !== 1'b0) begin
                $display("** Error (%0t): flip is %b after reset", $time, flip);
                n_fail++;
                n_errors++;
            end else begin
                $display("reset check ok");
            end
            preload_memories();
            for (int i = 0; i < case_op.size(); i++) begin
                errs = 0;
                case (case_op[i])
                    "W": begin
                        cpu_access(case_kind[i] == "V", 1'b0, case_addr[i], case_data[i], rdata);
                        apply_shadow(case_kind[i], case_addr[i], case_data[i]);
                        // Flip pin tracks cfg0 bit 6
                        if (flip !== shadow_cfg[0][6]) begin
                            $display("** Error (%0t): flip is %b, cfg0 bit 6 is %b",
                                     $time, flip, shadow_cfg[0][6]);
                            errs++;
                        end
                    end
                    "R": begin
                        cpu_access(case_kind[i] == "V", 1'b1, case_addr[i], 8'd0, rdata);
                        if (rdata !== case_data[i]) begin
                            $display("** Error (%0t): read %c %h got %h expected %h", $time,
                                     case_kind[i], case_addr[i], rdata, case_data[i]);
                            errs++;
                        end
                    end
                    "L": run_line(case_addr[i][8:0], errs);
                    default: begin
                        $display("Case %0d has an unknown operation %c", i + 1, case_op[i]);
                        errs = 1;
                    end
                endcase
                if (errs == 0) begin
                    $display("case %0d %c %h ok", i + 1, case_op[i], case_addr[i]);
                end else begin
                    $display("case %0d %c %h failed", i + 1, case_op[i], case_addr[i]);
                    n_fail++;
                end
                n_errors += errs;
            end
            $display("cases %0d, failed %0d, check errors %0d",
                     case_op.size() + 1, n_fail, n_errors);
            if (n_fail == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/gfx_cases.txt
# W kind addr data writes a byte, R kind addr data reads and compares the byte
# L line renders that line and checks all 256 pixels, kind V is video RAM and C control space
W V 0005 3c
W V 1005 a7
R V 0005 3c
R V 1005 a7
W V 0005 81
R V 1005 a7
R V 0005 81
W V 1005 c2
R V 0005 81
R V 1005 c2
W C 0010 5e
W C 0011 07
R C 0010 5e
R C 0011 07
R C 0300 ff
R C 0500 ff
W C 0300 10
W C 0301 00
L 003
L 0a5
W C 0300 50
W C 0301 50
W C 0003 e9
L 037
W C 0300 40
L 080

//--- sources.f
hdl/gfx_pkg.sv
hdl/tile_cfg_if.sv
hdl/dual_port_ram.sv
hdl/gfx_regs.sv
hdl/tilemap_fetch.sv
hdl/line_buffer.sv
hdl/gfx_top.sv
tests/gfx_tb.sv

//--- run.sh
#!/bin/sh
# Build the tile layer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module gfx_tb -f sources.f -o gfx_sim

out=$(./obj_dir/gfx_sim)
echo "$out"

# Passing run prints the pass line on its own
echo "$out" | grep -q "^test passed$"
